// ==== project.f ====
hdl/exec_pkg.sv
hdl/operand_mux.sv
hdl/alu_comb.sv
hdl/seq_multiplier.sv
hdl/exec_unit.sv
verif/exec_unit_tb.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := exec_unit_tb
RTL_TOP    := exec_unit
FILELIST   := project.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/exec_patterns.txt ====
// op sel_a sel_b rs1to32 pc rs1 rs2 csr imm expected_res
// all fields hex, op and select codes as in exec_pkg
00 1 1 0 0 1 2 0 0 3
00 0 0 0 1000 0 0 0 4 1004
00 1 2 0 0 10 0 20 0 30
00 1 1 1 0 ffffffff00000005 3 0 0 8
00 0 0 1 ffffffff00000000 0 0 0 1 ffffffff00000001
01 1 1 0 0 5 7 0 0 fffffffffffffffe
02 1 1 0 0 123456789abcdef0 0 0 0 123456789abcdef0
03 1 0 0 0 0 0 0 deadbeef deadbeef
03 1 2 0 0 0 0 cafe0000 0 cafe0000
04 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 f0f0f0f0f0f0f0f0
05 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 fff0fff0fff0fff0
06 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 0f000f000f000f00
0f 1 1 0 0 3 7 0 0 15
07 1 1 0 0 1 4 0 0 10
07 1 1 0 0 1 3f 0 0 8000000000000000
07 1 1 0 0 1 44 0 0 10
08 1 1 0 0 8000000000000000 20 0 0 80000000
08 1 1 0 0 ffffffffffffffff 28 0 0 ffffff
09 1 1 0 0 8000000000000000 4 0 0 f800000000000000
09 1 1 0 0 8000000000000000 24 0 0 fffffffff8000000
09 1 1 1 0 1234567880000000 4 0 0 f8000000
09 1 1 1 0 ffffffff80000000 1f 0 0 ffffffff
0a 1 1 0 0 ffffffffffffffff 1 0 0 1
0b 1 1 0 0 ffffffffffffffff 1 0 0 0
0b 1 1 0 0 1 ffffffffffffffff 0 0 1
0c 1 1 0 0 abc abc 0 0 1
0c 1 0 0 0 abc 0 0 abd 0
0d 1 1 0 0 ffffffffffffffff 1 0 0 0
0e 1 1 0 0 ffffffffffffffff 1 0 0 1
0d 1 1 0 0 7 7 0 0 1
0f 1 1 0 0 ffffffffffffffff 2 0 0 fffffffffffffffe
10 1 1 0 0 fffffffffffffff9 2 0 0 fffffffffffffffd
11 1 1 0 0 64 7 0 0 e
12 1 1 0 0 fffffffffffffff9 2 0 0 ffffffffffffffff
13 1 1 0 0 64 7 0 0 2
10 1 1 0 0 1234 0 0 0 ffffffffffffffff
11 1 1 0 0 1234 0 0 0 ffffffffffffffff
12 1 1 0 0 1234 0 0 0 1234
13 1 1 0 0 1234 0 0 0 1234
10 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
12 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0
0f 1 1 0 0 100000000 100000000 0 0 0

// ==== verif/exec_unit_tb.sv ====
`timescale 1ns/1ns

module exec_unit_tb import exec_pkg::*; ();

    localparam int NUM_PAT      = 42;
    localparam int PAT_FIELDS   = 10;
    localparam int NUM_RAND_MUL = 8;
    localparam int NUM_FLUSH    = 3;
    // every test item fits in one multiply plus a few cycles
    localparam int MAX_CYCLES   =
        (NUM_PAT + NUM_RAND_MUL + NUM_FLUSH) * (MUL_STEPS + 4) + 50;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    alu_op_e         op;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    logic            rs1to32;
    logic [XLEN-1:0] res;
    logic            alu_wait;

    logic [XLEN-1:0] pat_mem [0:NUM_PAT*PAT_FIELDS-1];
    logic [XLEN-1:0] last_res;
    int              error_count = 0;
    int              check_count = 0;
    int              cycle_count = 0;
    int              seed;

    exec_unit u_exec_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .op       (op),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .rs1to32  (rs1to32),
        .res      (res),
        .alu_wait (alu_wait)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_res(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_wait(input logic got, input logic exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apply_inputs(input alu_op_e op_v, input sel_a_e sa_v, input sel_b_e sb_v,
                                input logic w_v, input logic [XLEN-1:0] pc_v,
                                input logic [XLEN-1:0] rs1_v, input logic [XLEN-1:0] rs2_v,
                                input logic [XLEN-1:0] csr_v, input logic [XLEN-1:0] imm_v);
        op      = op_v;
        sel_a   = sa_v;
        sel_b   = sb_v;
        rs1to32 = w_v;
        pc      = pc_v;
        rs1     = rs1_v;
        rs2     = rs2_v;
        csr     = csr_v;
        imm     = imm_v;
    endtask

    // one-cycle op with its result visible at the next falling edge
    task automatic run_single(input logic [XLEN-1:0] exp, input string tag);
        @(negedge clk);
        check_res(res, exp, tag);
        check_wait(alu_wait, 1'b0, "alu_wait");
        last_res = exp;
    endtask

    task automatic run_multiply(input logic [XLEN-1:0] exp, input string tag);
        int busy_cycles;
        busy_cycles = 0;
        @(negedge clk);
        check_wait(alu_wait, 1'b1, "alu_wait after multiply start");
        // operands were latched at the start edge
        rs1 = ~rs1;
        rs2 = ~rs2;
        // bounded wait for alu_wait to drop
        while (alu_wait === 1'b1 && busy_cycles <= MUL_STEPS) begin
            check_res(res, last_res, "res while alu_wait high");
            busy_cycles++;
            @(negedge clk);
        end
        check_count++;
        if (busy_cycles != MUL_STEPS) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: alu_wait high cycles = %0d, expected %0d",
                     $time, busy_cycles, MUL_STEPS);
        end
        check_wait(alu_wait, 1'b0, "alu_wait after multiply");
        check_res(res, exp, tag);
        last_res = exp;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int              base;
        int              hold;
        logic [XLEN-1:0] a_val;
        logic [XLEN-1:0] b_val;

        seed     = 77;
        last_res = '0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        apply_inputs(OP_ADD, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, '0, '0, '0, '0);
        $readmemh("verif/exec_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[NUM_PAT*PAT_FIELDS-1])) begin
            error_count++;
            $display("pattern file holds fewer entries than the %0d patterns expected", NUM_PAT);
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_res(res, '0, "res after reset");
        check_wait(alu_wait, 1'b0, "alu_wait after reset");

        // directed replay with multiplies included
        for (int i = 0; i < NUM_PAT; i++) begin
            base = i * PAT_FIELDS;
            apply_inputs(alu_op_e'(pat_mem[base][4:0]), sel_a_e'(pat_mem[base+1][1:0]),
                         sel_b_e'(pat_mem[base+2][1:0]), pat_mem[base+3][0],
                         pat_mem[base+4], pat_mem[base+5], pat_mem[base+6],
                         pat_mem[base+7], pat_mem[base+8]);
            if (op == OP_MUL) begin
                run_multiply(pat_mem[base+9], $sformatf("res, pattern %0d", i));
            end else begin
                run_single(pat_mem[base+9], $sformatf("res, pattern %0d", i));
            end
        end

        // random back-to-back multiplies
        for (int n = 0; n < NUM_RAND_MUL; n++) begin
            a_val = {$random(seed), $random(seed)};
            b_val = {$random(seed), $random(seed)};
            apply_inputs(OP_MUL, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, a_val, b_val, '0, '0);
            run_multiply(a_val * b_val, $sformatf("res, random multiply %0d", n));
        end

        // abandon a multiply part way, then a plain add
        for (int n = 0; n < NUM_FLUSH; n++) begin
            a_val = {$random(seed), $random(seed)};
            b_val = {$random(seed), $random(seed)};
            hold  = 1 + int'($unsigned($random(seed)) % (MUL_STEPS - 1));
            apply_inputs(OP_MUL, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, a_val, b_val, '0, '0);
            repeat (hold) begin
                @(negedge clk);
                check_wait(alu_wait, 1'b1, "alu_wait before flush");
                check_res(res, last_res, "res before flush");
            end
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            check_wait(alu_wait, 1'b0, "alu_wait after flush");
            check_res(res, last_res, "res after flush");
            apply_inputs(OP_ADD, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, a_val, b_val, '0, '0);
            run_single(a_val + b_val, $sformatf("res, add after flush %0d", n));
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    input  alu_op_e         op,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            rs1to32,
    output logic [XLEN-1:0] res,
    output logic            alu_wait
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_product;
    logic            mul_busy;
    logic            mul_done;
    logic            mul_start;

    operand_mux u_operand_mux (
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .rs1to32 (rs1to32),
        .a       (a),
        .b       (b)
    );

    alu_comb u_alu_comb (
        .op      (op),
        .a       (a),
        .b       (b),
        .rs1to32 (rs1to32),
        .result  (alu_result)
    );

    // a new multiply only launches from idle
    assign mul_start = (op == OP_MUL) && !mul_busy;

    seq_multiplier u_seq_multiplier (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .flush   (flush),
        .a       (a),
        .b       (b),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_product)
    );

    // pipeline holds for the whole multiply
    assign alu_wait = mul_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else if (mul_done) begin
            res <= mul_product;
        end else if (op != OP_MUL) begin
            res <= alu_result;
        end
    end

endmodule

// ==== hdl/seq_multiplier.sv ====
`timescale 1ns/1ns

module seq_multiplier import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            flush,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] product
);

    mul_state_e           state;
    logic [MUL_CNT_W-1:0] step_cnt;
    logic [XLEN-1:0]      mcand;
    logic [XLEN-1:0]      mplier;
    logic [XLEN-1:0]      acc;
    logic [XLEN-1:0]      partial;
    logic                 last_step;

    // multiplicand times the current radix-16 digit
    assign partial   = mcand * XLEN'(mplier[MUL_DIGIT-1:0]);
    assign last_step = (step_cnt == MUL_CNT_W'(MUL_STEPS - 1));

    assign busy = (state == MUL_BUSY);
    // product is valid while the final step is being taken
    assign done    = busy && last_step && !flush;
    assign product = acc + partial;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MUL_IDLE;
            step_cnt <= '0;
        end else if (flush) begin
            state    <= MUL_IDLE;
            step_cnt <= '0;
        end else if (state == MUL_IDLE) begin
            if (start) begin
                state    <= MUL_BUSY;
                step_cnt <= '0;
            end
        end else begin
            step_cnt <= step_cnt + 1'b1;
            if (last_step) begin
                state <= MUL_IDLE;
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == MUL_IDLE && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == MUL_BUSY) begin
            acc    <= acc + partial;
            mcand  <= mcand << MUL_DIGIT;
            mplier <= mplier >> MUL_DIGIT;
        end
    end

endmodule

// ==== hdl/alu_comb.sv ====
`timescale 1ns/1ns

module alu_comb import exec_pkg::*; (
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic            rs1to32,
    output logic [XLEN-1:0] result
);

    localparam logic [XLEN-1:0] INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

    logic signed [XLEN-1:0]   sa;
    logic signed [XLEN-1:0]   sb;
    logic signed [XLEN/2-1:0] sa_lo;
    logic [SHAMT_W-1:0]       shamt;
    logic signed [XLEN-1:0]   sra_full;
    logic [XLEN-1:0]          sra_res;
    logic                     div_zero;
    logic                     div_ovf;
    logic signed [XLEN-1:0]   sdivisor;
    logic [XLEN-1:0]          udivisor;
    logic signed [XLEN-1:0]   sdiv_q;
    logic signed [XLEN-1:0]   sdiv_r;
    logic [XLEN-1:0]          quot_s;
    logic [XLEN-1:0]          rem_s;
    logic [XLEN-1:0]          quot_u;
    logic [XLEN-1:0]          rem_u;

    assign sa    = a;
    assign sb    = b;
    assign sa_lo = a[XLEN/2-1:0];
    assign shamt = b[SHAMT_W-1:0];

    assign sra_full = sa >>> shamt;
    // word form shifts the low half and leaves zeros on top
    assign sra_res = rs1to32 ? {{(XLEN/2){1'b0}}, sa_lo >>> shamt} : sra_full;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == INT_MIN) && (b == '1);

    // divide by one in the special cases, then patch the result
    assign sdivisor = (div_zero || div_ovf) ? XLEN'(1) : sb;
    assign udivisor = div_zero ? XLEN'(1) : b;

    // overflow needs no patch since MIN / 1 = MIN and MIN % 1 = 0
    assign sdiv_q = sa / sdivisor;
    assign sdiv_r = sa % sdivisor;

    assign quot_s = div_zero ? '1 : sdiv_q;
    assign rem_s  = div_zero ? a : sdiv_r;
    assign quot_u = div_zero ? '1 : a / udivisor;
    assign rem_u  = div_zero ? a : a % udivisor;

    always_comb begin
        case (op)
            OP_ADD:    result = a + b;
            OP_SUB:    result = a - b;
            OP_PASS_A: result = a;
            OP_PASS_B: result = b;
            OP_XOR:    result = a ^ b;
            OP_OR:     result = a | b;
            OP_AND:    result = a & b;
            OP_SLL:    result = a << shamt;
            OP_SRL:    result = a >> shamt;
            OP_SRA:    result = sra_res;
            OP_SLT:    result = XLEN'(sa < sb);
            OP_SLTU:   result = XLEN'(a < b);
            OP_EQ:     result = XLEN'(a == b);
            OP_GE:     result = XLEN'(sa >= sb);
            OP_GEU:    result = XLEN'(a >= b);
            OP_DIV:    result = quot_s;
            OP_DIVU:   result = quot_u;
            OP_REM:    result = rem_s;
            OP_REMU:   result = rem_u;
            // multiply comes from the sequential unit
            OP_MUL:    result = '0;
            default:   result = '0;
        endcase
    end

endmodule

// ==== hdl/operand_mux.sv ====
`timescale 1ns/1ns

module operand_mux import exec_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            rs1to32,
    output logic [XLEN-1:0] a,
    output logic [XLEN-1:0] b
);

    logic [XLEN-1:0] rs1_eff;

    // word ops see only the low half of rs1
    assign rs1_eff = rs1to32 ? {{(XLEN/2){1'b0}}, rs1[XLEN/2-1:0]} : rs1;

    assign a = (sel_a == SEL_A_RS1) ? rs1_eff : pc;

    always_comb begin
        case (sel_b)
            SEL_B_RS2: b = rs2;
            SEL_B_CSR: b = csr;
            default:   b = imm;
        endcase
    end

endmodule

// ==== hdl/exec_pkg.sv ====
package exec_pkg;

    // datapath widths
    localparam int XLEN    = 64;
    localparam int SHAMT_W = 6;

    // iterative multiplier geometry
    localparam int MUL_DIGIT = 4;
    localparam int MUL_STEPS = XLEN / MUL_DIGIT;
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_PASS_A = 5'd2,
        OP_PASS_B = 5'd3,
        OP_XOR    = 5'd4,
        OP_OR     = 5'd5,
        OP_AND    = 5'd6,
        OP_SLL    = 5'd7,
        OP_SRL    = 5'd8,
        OP_SRA    = 5'd9,
        OP_SLT    = 5'd10,
        OP_SLTU   = 5'd11,
        OP_EQ     = 5'd12,
        OP_GE     = 5'd13,
        OP_GEU    = 5'd14,
        OP_MUL    = 5'd15,
        OP_DIV    = 5'd16,
        OP_DIVU   = 5'd17,
        OP_REM    = 5'd18,
        OP_REMU   = 5'd19
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } sel_a_e;

    // second operand source
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_e;

    typedef enum logic {
        MUL_IDLE = 1'b0,
        MUL_BUSY = 1'b1
    } mul_state_e;

endpackage
